/* cookie_pkg.sv */
// Widths, work memory block map and cookie field codes shared by the unwrap front end
// Blocks are big-endian in words: word 0 sits in the top 32 bits of a block
`default_nettype none

package cookie_pkg;

  // --------------------
  // Word and key widths
  // --------------------
  localparam int WORD_W    = 32;
  localparam int BLOCK_W   = 128;
  localparam int KEY_W     = 512;
  localparam int KEY_WORDS = 16;
  localparam int IDX_W     = 4;

  // --------------------
  // Image block map
  // --------------------
  localparam int BLK_IDX_W    = 3;
  localparam int IMAGE_BLOCKS = 6;

  // Associated data is the key identifier followed by zeros
  localparam logic [BLK_IDX_W-1:0] BLK_AD    = 3'd0;
  localparam logic [BLK_IDX_W-1:0] BLK_NONCE = 3'd1;
  // C2S and S2C each span two blocks with words 0-3 then 4-7
  localparam logic [BLK_IDX_W-1:0] BLK_C2S   = 3'd2;
  localparam logic [BLK_IDX_W-1:0] BLK_S2C   = 3'd4;

  // Cookie field selected by a cookie write
  typedef enum logic [1:0] {
    FIELD_NONCE = 2'd0,
    FIELD_C2S   = 2'd1,
    FIELD_S2C   = 2'd2,
    FIELD_TAG   = 2'd3
  } cookie_field_e;

endpackage

`default_nettype wire

/* key_store.sv */
// Server key staging; writes are dropped while i_write_lock is high
// Identifier and length flag are taken from every accepted key word write
`timescale 1ns/1ns
`default_nettype none

module key_store (
  input  wire                              i_clk,
  input  wire                              i_areset,
  input  wire                              i_write_lock,
  input  wire                              i_key_we,
  input  wire  [cookie_pkg::IDX_W-1:0]     i_key_word,
  input  wire  [cookie_pkg::WORD_W-1:0]    i_key_data,
  input  wire  [cookie_pkg::WORD_W-1:0]    i_key_id,
  input  wire                              i_key_length,
  output logic [cookie_pkg::WORD_W-1:0]    o_key_id,
  output logic [cookie_pkg::KEY_W-1:0]     o_aead_key,
  output logic                             o_aead_mode
);

  logic [cookie_pkg::WORD_W-1:0] key_q [cookie_pkg::KEY_WORDS];
  logic [cookie_pkg::WORD_W-1:0] key_id_q;
  logic                          length_q;
  logic                          write_en;

  assign write_en = i_key_we && !i_write_lock;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < cookie_pkg::KEY_WORDS; i++) begin
        key_q[i] <= '0;
      end
      key_id_q <= '0;
      length_q <= 1'b0;
    end else if (write_en) begin
      key_q[i_key_word] <= i_key_data;
      key_id_q          <= i_key_id;
      length_q          <= i_key_length;
    end
  end

  // --------------------
  // Key arrangement
  // --------------------
  // 512 bits take words 0-15 from the top down
  // 256 bits take words 8-11, zeros, words 12-15 and zeros
  always_comb begin
    o_aead_key = '0;
    if (length_q) begin
      for (int i = 0; i < cookie_pkg::KEY_WORDS; i++) begin
        o_aead_key[cookie_pkg::KEY_W-1-i*cookie_pkg::WORD_W -: cookie_pkg::WORD_W] = key_q[i];
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        o_aead_key[cookie_pkg::KEY_W-1-i*cookie_pkg::WORD_W -: cookie_pkg::WORD_W] =
          key_q[8+i];
        o_aead_key[cookie_pkg::KEY_W/2-1-i*cookie_pkg::WORD_W -: cookie_pkg::WORD_W] =
          key_q[12+i];
      end
    end
  end

  assign o_key_id    = key_id_q;
  // Mode 1 selects the 512-bit engine variant
  assign o_aead_mode = length_q;

endmodule

`default_nettype wire

/* cookie_store.sv */
// Cookie field staging and image block assembly
// Nonce and tag use word index bits [1:0]; C2S and S2C use bits [2:0]
`timescale 1ns/1ns
`default_nettype none

module cookie_store (
  input  wire                                 i_clk,
  input  wire                                 i_areset,
  input  wire                                 i_write_lock,
  input  wire                                 i_cookie_we,
  input  wire  cookie_pkg::cookie_field_e     i_cookie_field,
  input  wire  [cookie_pkg::IDX_W-1:0]        i_cookie_word,
  input  wire  [cookie_pkg::WORD_W-1:0]       i_cookie_data,
  input  wire  [cookie_pkg::WORD_W-1:0]       i_key_id,
  input  wire  [cookie_pkg::BLK_IDX_W-1:0]    i_block_index,
  output logic [cookie_pkg::BLOCK_W-1:0]      o_block,
  output logic [cookie_pkg::BLOCK_W-1:0]      o_aead_tag
);

  logic [cookie_pkg::WORD_W-1:0] nonce_q [4];
  logic [cookie_pkg::WORD_W-1:0] c2s_q   [8];
  logic [cookie_pkg::WORD_W-1:0] s2c_q   [8];
  logic [cookie_pkg::WORD_W-1:0] tag_q   [4];
  logic                          write_en;

  assign write_en = i_cookie_we && !i_write_lock;

  // --------------------
  // Field registers
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < 4; i++) begin
        nonce_q[i] <= '0;
        tag_q[i]   <= '0;
      end
      for (int i = 0; i < 8; i++) begin
        c2s_q[i] <= '0;
        s2c_q[i] <= '0;
      end
    end else if (write_en) begin
      case (i_cookie_field)
        cookie_pkg::FIELD_NONCE: nonce_q[i_cookie_word[1:0]] <= i_cookie_data;
        cookie_pkg::FIELD_C2S:   c2s_q[i_cookie_word[2:0]]   <= i_cookie_data;
        cookie_pkg::FIELD_S2C:   s2c_q[i_cookie_word[2:0]]   <= i_cookie_data;
        cookie_pkg::FIELD_TAG:   tag_q[i_cookie_word[1:0]]   <= i_cookie_data;
        default: ;
      endcase
    end
  end

  // --------------------
  // Image block assembly
  // --------------------
  always_comb begin
    case (i_block_index)
      cookie_pkg::BLK_AD:
        o_block = {i_key_id, {(cookie_pkg::BLOCK_W - cookie_pkg::WORD_W){1'b0}}};
      cookie_pkg::BLK_NONCE:
        o_block = {nonce_q[0], nonce_q[1], nonce_q[2], nonce_q[3]};
      cookie_pkg::BLK_C2S:
        o_block = {c2s_q[0], c2s_q[1], c2s_q[2], c2s_q[3]};
      cookie_pkg::BLK_C2S + 3'd1:
        o_block = {c2s_q[4], c2s_q[5], c2s_q[6], c2s_q[7]};
      cookie_pkg::BLK_S2C:
        o_block = {s2c_q[0], s2c_q[1], s2c_q[2], s2c_q[3]};
      cookie_pkg::BLK_S2C + 3'd1:
        o_block = {s2c_q[4], s2c_q[5], s2c_q[6], s2c_q[7]};
      default:
        o_block = '0;
    endcase
  end

  // Expected tag for the engine with word 0 on top
  assign o_aead_tag = {tag_q[0], tag_q[1], tag_q[2], tag_q[3]};

endmodule

`default_nettype wire

/* work_memory.sv */
// Single-port block RAM; ack follows a select by one cycle, read data is valid with ack
// MEM_BLOCKS must be at least 8; the engine owns the port while i_engine_owns is high
`timescale 1ns/1ns
`default_nettype none

module work_memory #(
  parameter int MEM_BLOCKS = 8
) (
  input  wire                                 i_clk,
  input  wire                                 i_areset,
  input  wire                                 i_engine_owns,
  input  wire                                 i_load_write,
  input  wire  [cookie_pkg::BLK_IDX_W-1:0]    i_load_addr,
  input  wire  [cookie_pkg::BLOCK_W-1:0]      i_load_block,
  input  wire                                 i_aead_cs,
  input  wire                                 i_aead_we,
  input  wire  [$clog2(MEM_BLOCKS)-1:0]       i_aead_addr,
  input  wire  [cookie_pkg::BLOCK_W-1:0]      i_aead_block_wr,
  output logic                                o_ack,
  output logic [cookie_pkg::BLOCK_W-1:0]      o_block_rd
);

  localparam int ADDR_W = $clog2(MEM_BLOCKS);

  logic [cookie_pkg::BLOCK_W-1:0] mem [MEM_BLOCKS];
  logic                           mem_cs;
  logic                           mem_we;
  logic [ADDR_W-1:0]              mem_addr;
  logic [cookie_pkg::BLOCK_W-1:0] mem_wdata;

  // Port owner select; the loader only ever writes
  always_comb begin
    if (i_engine_owns) begin
      mem_cs    = i_aead_cs;
      mem_we    = i_aead_we;
      mem_addr  = i_aead_addr;
      mem_wdata = i_aead_block_wr;
    end else begin
      mem_cs    = i_load_write;
      mem_we    = 1'b1;
      mem_addr  = ADDR_W'(i_load_addr);
      mem_wdata = i_load_block;
    end
  end

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge i_clk) begin
    if (mem_cs) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        o_block_rd <= mem[mem_addr];
      end
    end
  end

  // Acknowledge of every selected cycle
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= mem_cs;
    end
  end

endmodule

`default_nettype wire

/* block_load_counter.sv */
// Image block index for the load phase
// Index runs past the last block once after its ack; it is cleared before the next load
`timescale 1ns/1ns
`default_nettype none

module block_load_counter (
  input  wire                               i_clk,
  input  wire                               i_areset,
  input  wire                               i_clear,
  input  wire                               i_step,
  output logic [cookie_pkg::BLK_IDX_W-1:0]  o_index,
  output logic                              o_last
);

  logic [cookie_pkg::BLK_IDX_W-1:0] index_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      index_q <= '0;
    end else if (i_clear) begin
      index_q <= '0;
    end else if (i_step) begin
      index_q <= index_q + 1'b1;
    end
  end

  assign o_index = index_q;

  // Final block of the image
  assign o_last = (index_q == cookie_pkg::BLK_IDX_W'(cookie_pkg::IMAGE_BLOCKS - 1));

endmodule

`default_nettype wire

/* unwrap_fsm.sv */
// Unwrap sequencer: command, image load, engine start and wait, result handshake
// One unwrap in flight; a pending result keeps o_unwrap_ready low
`timescale 1ns/1ns
`default_nettype none

module unwrap_fsm (
  input  wire   i_clk,
  input  wire   i_areset,
  input  wire   i_unwrap_valid,
  input  wire   i_result_ready,
  input  wire   i_mem_ack,
  input  wire   i_last_block,
  input  wire   i_aead_done,
  input  wire   i_aead_tag_ok,
  output logic  o_unwrap_ready,
  output logic  o_busy,
  output logic  o_load_write,
  output logic  o_count_clear,
  output logic  o_count_step,
  output logic  o_engine_owns,
  output logic  o_aead_start,
  output logic  o_result_valid,
  output logic  o_tag_ok
);

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOAD   = 3'd1,
    START  = 3'd2,
    RUN    = 3'd3,
    RESULT = 3'd4
  } state_e;

  state_e state_q;
  logic   wait_ack_q;
  logic   tag_ok_q;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q    <= IDLE;
      wait_ack_q <= 1'b0;
      tag_ok_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_unwrap_valid) begin
            state_q    <= LOAD;
            wait_ack_q <= 1'b0;
          end
        end
        LOAD: begin
          // Write one block, then wait for its ack
          if (!wait_ack_q) begin
            wait_ack_q <= 1'b1;
          end else if (i_mem_ack) begin
            wait_ack_q <= 1'b0;
            if (i_last_block) begin
              state_q <= START;
            end
          end
        end
        START: state_q <= RUN;
        RUN: begin
          if (i_aead_done) begin
            tag_ok_q <= i_aead_tag_ok;
            state_q  <= RESULT;
          end
        end
        RESULT: begin
          if (i_result_ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign o_unwrap_ready = (state_q == IDLE);
  assign o_busy         = (state_q != IDLE);
  assign o_count_clear  = (state_q == IDLE) && i_unwrap_valid;
  assign o_load_write   = (state_q == LOAD) && !wait_ack_q;
  assign o_count_step   = (state_q == LOAD) && wait_ack_q && i_mem_ack;
  assign o_aead_start   = (state_q == START);
  assign o_engine_owns  = (state_q == RUN);
  assign o_result_valid = (state_q == RESULT);
  assign o_tag_ok       = tag_ok_q;

endmodule

`default_nettype wire

/* cookie_unwrap.sv */
// NTS cookie unwrap front end; the AEAD engine sits outside on the o_aead/i_aead ports
// Key and cookie writes are ignored while an unwrap is in flight
`timescale 1ns/1ns
`default_nettype none

module cookie_unwrap #(
  parameter int MEM_BLOCKS = 8
) (
  input  wire                                i_clk,
  input  wire                                i_areset,
  // Key staging
  input  wire                                i_key_we,
  input  wire  [cookie_pkg::IDX_W-1:0]       i_key_word,
  input  wire  [cookie_pkg::WORD_W-1:0]      i_key_data,
  input  wire  [cookie_pkg::WORD_W-1:0]      i_key_id,
  input  wire                                i_key_length,
  // Cookie staging
  input  wire                                i_cookie_we,
  input  wire  cookie_pkg::cookie_field_e    i_cookie_field,
  input  wire  [cookie_pkg::IDX_W-1:0]       i_cookie_word,
  input  wire  [cookie_pkg::WORD_W-1:0]      i_cookie_data,
  // Command and result
  input  wire                                i_unwrap_valid,
  output logic                               o_unwrap_ready,
  output logic                               o_result_valid,
  output logic                               o_tag_ok,
  input  wire                                i_result_ready,
  // AEAD engine
  output logic                               o_aead_start,
  output logic [cookie_pkg::KEY_W-1:0]       o_aead_key,
  output logic                               o_aead_mode,
  output logic [cookie_pkg::BLOCK_W-1:0]     o_aead_tag,
  input  wire                                i_aead_cs,
  input  wire                                i_aead_we,
  input  wire  [$clog2(MEM_BLOCKS)-1:0]      i_aead_addr,
  input  wire  [cookie_pkg::BLOCK_W-1:0]     i_aead_block_wr,
  output logic [cookie_pkg::BLOCK_W-1:0]     o_aead_block_rd,
  output logic                               o_aead_ack,
  input  wire                                i_aead_done,
  input  wire                                i_aead_tag_ok
);

  logic                             busy;
  logic                             load_write;
  logic                             count_clear;
  logic                             count_step;
  logic                             engine_owns;
  logic                             last_block;
  logic [cookie_pkg::BLK_IDX_W-1:0] block_index;
  logic [cookie_pkg::WORD_W-1:0]    key_id;
  logic [cookie_pkg::BLOCK_W-1:0]   load_block;

  // --------------------
  // Control
  // --------------------
  unwrap_fsm u_fsm (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_unwrap_valid (i_unwrap_valid),
    .i_result_ready (i_result_ready),
    .i_mem_ack      (o_aead_ack),
    .i_last_block   (last_block),
    .i_aead_done    (i_aead_done),
    .i_aead_tag_ok  (i_aead_tag_ok),
    .o_unwrap_ready (o_unwrap_ready),
    .o_busy         (busy),
    .o_load_write   (load_write),
    .o_count_clear  (count_clear),
    .o_count_step   (count_step),
    .o_engine_owns  (engine_owns),
    .o_aead_start   (o_aead_start),
    .o_result_valid (o_result_valid),
    .o_tag_ok       (o_tag_ok)
  );

  block_load_counter u_counter (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_clear  (count_clear),
    .i_step   (count_step),
    .o_index  (block_index),
    .o_last   (last_block)
  );

  // --------------------
  // Data
  // --------------------
  key_store u_key_store (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_write_lock (busy),
    .i_key_we     (i_key_we),
    .i_key_word   (i_key_word),
    .i_key_data   (i_key_data),
    .i_key_id     (i_key_id),
    .i_key_length (i_key_length),
    .o_key_id     (key_id),
    .o_aead_key   (o_aead_key),
    .o_aead_mode  (o_aead_mode)
  );

  cookie_store u_cookie_store (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_write_lock   (busy),
    .i_cookie_we    (i_cookie_we),
    .i_cookie_field (i_cookie_field),
    .i_cookie_word  (i_cookie_word),
    .i_cookie_data  (i_cookie_data),
    .i_key_id       (key_id),
    .i_block_index  (block_index),
    .o_block        (load_block),
    .o_aead_tag     (o_aead_tag)
  );

  work_memory #(
    .MEM_BLOCKS (MEM_BLOCKS)
  ) u_work_memory (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_engine_owns   (engine_owns),
    .i_load_write    (load_write),
    .i_load_addr     (block_index),
    .i_load_block    (load_block),
    .i_aead_cs       (i_aead_cs),
    .i_aead_we       (i_aead_we),
    .i_aead_addr     (i_aead_addr),
    .i_aead_block_wr (i_aead_block_wr),
    .o_ack           (o_aead_ack),
    .o_block_rd      (o_aead_block_rd)
  );

endmodule

`default_nettype wire

/* cookie_unwrap_chk.sv */
// Handshake and memory port properties, bound into every cookie_unwrap instance
// Memory select is rebuilt from the loader and engine selects at the top level
`timescale 1ns/1ns
`default_nettype none

module cookie_unwrap_chk (
  input wire i_clk,
  input wire i_areset,
  input wire i_aead_start,
  input wire i_result_valid,
  input wire i_tag_ok,
  input wire i_result_ready,
  input wire i_unwrap_ready,
  input wire i_ack,
  input wire i_load_write,
  input wire i_engine_owns,
  input wire i_aead_cs
);

  logic mem_sel;

  assign mem_sel = i_engine_owns ? i_aead_cs : i_load_write;

  start_pulse: assert property (@(posedge i_clk) disable iff (i_areset)
    i_aead_start |=> !i_aead_start)
    else $error("o_aead_start high for more than one cycle");

  // Result held until the edge that accepts it
  result_hold: assert property (@(posedge i_clk) disable iff (i_areset)
    i_result_valid && !i_result_ready |=> i_result_valid && $stable(i_tag_ok))
    else $error("result changed before it was accepted");

  ready_blocked: assert property (@(posedge i_clk) disable iff (i_areset)
    i_result_valid |-> !i_unwrap_ready)
    else $error("o_unwrap_ready high while a result is pending");

  ack_after_select: assert property (@(posedge i_clk) disable iff (i_areset)
    i_ack |-> $past(mem_sel))
    else $error("o_aead_ack without a memory select in the cycle before");

endmodule

bind cookie_unwrap cookie_unwrap_chk u_chk (
  .i_clk          (i_clk),
  .i_areset       (i_areset),
  .i_aead_start   (o_aead_start),
  .i_result_valid (o_result_valid),
  .i_tag_ok       (o_tag_ok),
  .i_result_ready (i_result_ready),
  .i_unwrap_ready (o_unwrap_ready),
  .i_ack          (o_aead_ack),
  .i_load_write   (load_write),
  .i_engine_owns  (engine_owns),
  .i_aead_cs      (i_aead_cs)
);

`default_nettype wire

/* tb_cookie_unwrap.sv */
// Testbench for cookie_unwrap; the engine model reads the image and checks the tag by XOR
// Stimulus words come from a Galois LFSR with a fixed seed
`timescale 1ns/1ns
`default_nettype none

module tb_cookie_unwrap;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 5;
  localparam int MEM_BLOCKS  = 8;
  localparam int ADDR_W      = $clog2(MEM_BLOCKS);
  localparam int N_UNWRAPS   = 23;
  localparam int WATCHDOG_NS = 2 * N_UNWRAPS * 200 * CLK_PERIOD;

  logic i_clk, i_areset, i_key_we, i_key_length, i_cookie_we;
  logic [3:0] i_key_word, i_cookie_word;
  logic [31:0] i_key_data, i_key_id, i_cookie_data;
  cookie_pkg::cookie_field_e i_cookie_field;
  logic i_unwrap_valid, o_unwrap_ready, o_result_valid, o_tag_ok, i_result_ready;
  logic o_aead_start, o_aead_mode, i_aead_cs, i_aead_we, o_aead_ack;
  logic i_aead_done, i_aead_tag_ok;
  logic [511:0] o_aead_key;
  logic [127:0] o_aead_tag, i_aead_block_wr, o_aead_block_rd;
  logic [ADDR_W-1:0] i_aead_addr;

  // Words as written and blocks as read by the engine model
  logic [31:0] ref_key_w [16];
  logic [31:0] ref_nonce [4];
  logic [31:0] ref_c2s [8];
  logic [31:0] ref_s2c [8];
  logic [31:0] ref_tag [4];
  logic [31:0] ref_key_id, lfsr_state;
  logic ref_len;
  logic [127:0] eng_blk [6];
  int checks, errors, unwraps, results;

  cookie_unwrap #(.MEM_BLOCKS(MEM_BLOCKS)) dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [127:0] image_block(input int b);
    logic [127:0] blk;
    blk = '0;
    for (int w = 0; w < 4; w++) begin
      case (b)
        0: blk = {blk[95:0], (w == 0) ? ref_key_id : 32'd0};
        1: blk = {blk[95:0], ref_nonce[w]};
        2, 3: blk = {blk[95:0], ref_c2s[4*(b-2)+w]};
        default: blk = {blk[95:0], ref_s2c[4*(b-4)+w]};
      endcase
    end
    return blk;
  endfunction

  function automatic logic [511:0] arranged_key();
    logic [511:0] k;
    k = '0;
    for (int i = 0; i < 16; i++) begin
      if (ref_len) k[511-32*i -: 32] = ref_key_w[i];
    end
    // 256-bit layout puts zero halves under each 128-bit key part
    for (int i = 0; i < 4; i++) begin
      if (!ref_len) begin
        k[511-32*i -: 32] = ref_key_w[8+i];
        k[255-32*i -: 32] = ref_key_w[12+i];
      end
    end
    return k;
  endfunction

  function automatic logic [127:0] image_xor();
    logic [127:0] acc;
    acc = '0;
    for (int b = 0; b < 6; b++) acc = acc ^ image_block(b);
    return acc;
  endfunction

  function automatic logic [127:0] written_tag();
    return {ref_tag[0], ref_tag[1], ref_tag[2], ref_tag[3]};
  endfunction

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic write_key(input int word, input logic [31:0] data);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_cookie_we  = 1'b0;
    i_key_we     = 1'b1;
    i_key_word   = 4'(word);
    i_key_data   = data;
    i_key_id     = ref_key_id;
    i_key_length = ref_len;
  endtask

  task automatic write_cookie(input cookie_pkg::cookie_field_e field, input int word,
                              input logic [31:0] data);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_key_we       = 1'b0;
    i_cookie_we    = 1'b1;
    i_cookie_field = field;
    i_cookie_word  = 4'(word);
    i_cookie_data  = data;
  endtask

  // Fresh key and cookie with a tag that matches the image unless corrupted in one bit
  task automatic prepare(input logic len, input logic corrupt);
    logic [127:0] x;
    ref_len    = len;
    ref_key_id = draw(32);
    for (int i = 0; i < 16; i++) begin
      ref_key_w[i] = draw(32);
      write_key(i, ref_key_w[i]);
    end
    for (int i = 0; i < 4; i++) begin
      ref_nonce[i] = draw(32);
      write_cookie(cookie_pkg::FIELD_NONCE, i, ref_nonce[i]);
    end
    for (int i = 0; i < 8; i++) begin
      ref_c2s[i] = draw(32);
      write_cookie(cookie_pkg::FIELD_C2S, i, ref_c2s[i]);
      ref_s2c[i] = draw(32);
      write_cookie(cookie_pkg::FIELD_S2C, i, ref_s2c[i]);
    end
    x = image_xor();
    if (corrupt) x = x ^ (128'd1 << draw(7));
    for (int i = 0; i < 4; i++) begin
      ref_tag[i] = x[127-32*i -: 32];
      write_cookie(cookie_pkg::FIELD_TAG, i, ref_tag[i]);
    end
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_cookie_we = 1'b0;
  endtask

  // Holds the result for some cycles while junk writes and a new command are offered
  task automatic run_unwrap(input int hold);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_unwrap_valid = 1'b1;
    @(negedge i_clk);
    while (!o_unwrap_ready) @(negedge i_clk);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_unwrap_valid = 1'b0;
    @(negedge i_clk);
    while (!o_result_valid) @(negedge i_clk);
    for (int i = 0; i < hold; i++) begin
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_unwrap_valid = 1'b1;
      i_key_we       = 1'b1;
      i_key_word     = 4'(draw(4));
      i_key_data     = draw(32);
      i_key_id       = draw(32);
      i_key_length   = 1'(draw(1));
      i_cookie_we    = 1'b1;
      i_cookie_field = cookie_pkg::cookie_field_e'(draw(2));
      i_cookie_word  = 4'(draw(4));
      i_cookie_data  = draw(32);
    end
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_unwrap_valid = 1'b0;
    i_key_we       = 1'b0;
    i_cookie_we    = 1'b0;
    i_result_ready = 1'b1;
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_result_ready = 1'b0;
    unwraps++;
  endtask

  // --------------------
  // Engine model
  // --------------------
  initial begin
    logic [127:0] acc;
    i_aead_cs       = 1'b0;
    i_aead_we       = 1'b0;
    i_aead_addr     = '0;
    i_aead_block_wr = '0;
    i_aead_done     = 1'b0;
    i_aead_tag_ok   = 1'b0;
    forever begin
      @(negedge i_clk);
      while (!o_aead_start) @(negedge i_clk);
      acc = '0;
      for (int b = 0; b < cookie_pkg::IMAGE_BLOCKS; b++) begin
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_aead_cs   = 1'b1;
        i_aead_addr = ADDR_W'(b);
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_aead_cs = 1'b0;
        @(negedge i_clk);
        while (!o_aead_ack) @(negedge i_clk);
        eng_blk[b] = o_aead_block_rd;
        acc        = acc ^ o_aead_block_rd;
      end
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_aead_done   = 1'b1;
      i_aead_tag_ok = (acc == o_aead_tag);
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_aead_done = 1'b0;
    end
  end

  // --------------------
  // Compare process
  // --------------------
  logic start_q, result_q, tag_q, ready_q, cs_q;
  logic loading, engine_phase;
  int load_acks;

  always @(negedge i_clk) begin
    if (!i_areset && o_result_valid && !result_q) begin
      results++;
      for (int b = 0; b < 6; b++) begin
        check_value($sformatf("engine block %0d", b), eng_blk[b], image_block(b));
      end
      check_value("o_aead_key", o_aead_key, arranged_key());
      check_value("o_aead_mode", o_aead_mode, ref_len);
      check_value("o_aead_tag", o_aead_tag, written_tag());
      check_value("o_tag_ok", o_tag_ok, image_xor() == written_tag());
    end
    if (o_result_valid) check_value("o_unwrap_ready", o_unwrap_ready, 1'b0);
    // A result that was not accepted stays unchanged
    if (result_q && !ready_q) begin
      check_value("o_result_valid held", o_result_valid, 1'b1);
      check_value("o_tag_ok held", o_tag_ok, tag_q);
    end
    if (o_aead_start) check_value("o_aead_start pulse", start_q, 1'b0);
    // Acks answer the engine's own selects or the six block writes of a load
    if (o_aead_ack) begin
      if (engine_phase) begin
        check_value("i_aead_cs before o_aead_ack", cs_q, 1'b1);
      end else if (loading) begin
        load_acks++;
      end else begin
        check_value("o_aead_ack outside a load or engine read", o_aead_ack, 1'b0);
      end
    end
    if (o_unwrap_ready && i_unwrap_valid) begin
      loading   = 1'b1;
      load_acks = 0;
    end
    if (o_aead_start) begin
      check_value("load acks before o_aead_start", load_acks, 6);
      loading      = 1'b0;
      engine_phase = 1'b1;
    end
    if (i_aead_done) engine_phase = 1'b0;
    result_q = o_result_valid;
    ready_q  = i_result_ready;
    tag_q    = o_tag_ok;
    start_q  = o_aead_start;
    cs_q     = i_aead_cs;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired after %0d ns, unwraps did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    {checks, errors, unwraps, results} = '0;
    {start_q, result_q, tag_q, ready_q, cs_q} = '0;
    {loading, engine_phase} = '0;
    load_acks      = 0;
    lfsr_state     = 32'h0f23_96a8;
    i_areset       = 1'b1;
    {i_key_we, i_key_length, i_cookie_we, i_unwrap_valid, i_result_ready} = '0;
    {i_key_word, i_cookie_word, i_key_data, i_key_id, i_cookie_data} = '0;
    i_cookie_field = cookie_pkg::FIELD_NONCE;
    repeat (4) @(posedge i_clk);
    #DRIVE_DELAY;
    i_areset = 1'b0;
    @(negedge i_clk);
    check_value("o_unwrap_ready after reset", o_unwrap_ready, 1'b1);
    check_value("o_result_valid after reset", o_result_valid, 1'b0);
    check_value("o_aead_start after reset", o_aead_start, 1'b0);
    // 512-bit key with a good tag and then a 256-bit key with a bad tag run twice
    prepare(1'b1, 1'b0);
    run_unwrap(4);
    prepare(1'b0, 1'b1);
    run_unwrap(3);
    run_unwrap(0);
    for (int n = 0; n < 20; n++) begin
      prepare(1'(draw(1)), 1'(draw(1)));
      run_unwrap(int'(draw(2)));
    end
    repeat (2) @(posedge i_clk);
    check_value("result count", results, unwraps);
    $display("Unwraps: %0d, checks: %0d, errors: %0d", unwraps, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cookie_unwrap.f */
cookie_pkg.sv
key_store.sv
cookie_store.sv
work_memory.sv
block_load_counter.sv
unwrap_fsm.sv
cookie_unwrap.sv
cookie_unwrap_chk.sv
tb_cookie_unwrap.sv
